// File: filelist.f
hw/rv32_decode_pkg.sv
hw/rv32_instr_classifier.sv
hw/rv32_alu_ctrl.sv
hw/rv32_mem_branch_ctrl.sv
hw/rv32_reg_csr_ctrl.sv
hw/rv32_decode_stage.sv
sim/tb_clock_gen.sv
sim/rv32_decode_properties.sv
sim/rv32_decode_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv32_decode_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/rv32_decode_tb.sv
module rv32_decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32_decode_pkg::*;

    localparam int          NUM_INSTR      = 400;
    localparam int          TIMEOUT_CYCLES = 2 * NUM_INSTR + 50;
    localparam int          CW_W           = 27;
    localparam int unsigned SEED           = 32'hb8f4_5a0a;

    logic           clk;
    logic           rst_n;
    logic           instr_valid;
    logic [31:0]    instr;
    logic           out_valid;
    logic           legal;
    logic           rs1_read;
    logic           rs2_read;
    imm_fmt_e       imm_fmt;
    alu_op_e        alu_op;
    logic           alu_sub_sra;
    alu_src1_e      alu_src1;
    alu_src2_e      alu_src2;
    logic           mem_read;
    logic           mem_write;
    mem_width_e     mem_width;
    logic           mem_zero_extend;
    logic           csr_read;
    logic           csr_write;
    csr_write_op_e  csr_write_op;
    branch_op_e     branch_op;
    branch_pc_src_e branch_pc_src;
    logic           rd_write;

    logic [31:0] sent_q[$];
    string       name_q[$];
    int          checked_count = 0;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv32_decode_stage u_rv32_decode_stage (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Expected control word
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [CW_W-1:0] ref_decode(input logic [31:0] w);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       lg;
        logic       r1;
        logic       r2;
        logic       rdw;
        logic       sub;
        logic       mr;
        logic       mw;
        logic       zx;
        logic       cr;
        logic       cw;
        logic       pcs;
        logic [2:0] imm;
        logic [2:0] op;
        logic [1:0] s1;
        logic [1:0] s2;
        logic [1:0] wd;
        logic [1:0] cop;
        logic [1:0] br;
        opc = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        {lg, r1, r2, rdw, sub, mr, mw, zx, cr, cw, pcs} = '0;
        {imm, op, s1, s2, wd, cop, br} = '0;    // An illegal word keeps every field zero
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                lg  = 1'b1;
                rdw = 1'b1;
                imm = IMM_U;
                s1  = (opc == OPC_LUI) ? SRC1_ZERO : SRC1_PC;
                s2  = SRC2_IMM;
            end
            OPC_JAL, OPC_JALR: begin
                if (opc == OPC_JAL || f3 == 3'd0) begin
                    lg  = 1'b1;
                    rdw = 1'b1;
                    r1  = (opc == OPC_JALR);
                    pcs = (opc == OPC_JALR);
                    imm = (opc == OPC_JAL) ? IMM_J : IMM_I;
                    s1  = SRC1_PC;
                    s2  = SRC2_FOUR;
                    br  = BR_ALWAYS;
                end
            end
            OPC_BRANCH: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    lg  = 1'b1;
                    r1  = 1'b1;
                    r2  = 1'b1;
                    sub = 1'b1;
                    imm = IMM_B;
                    op  = !f3[2] ? ALU_ADD_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
                    br  = (f3 inside {3'd1, 3'd4, 3'd6}) ? BR_NON_ZERO : BR_ZERO;
                end
            end
            OPC_LOAD, OPC_STORE: begin
                if ((opc == OPC_LOAD && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ||
                    (opc == OPC_STORE && f3 inside {3'd0, 3'd1, 3'd2})) begin
                    lg  = 1'b1;
                    r1  = 1'b1;
                    r2  = (opc == OPC_STORE);
                    rdw = (opc == OPC_LOAD);
                    mr  = (opc == OPC_LOAD);
                    mw  = (opc == OPC_STORE);
                    zx  = (opc == OPC_LOAD) && f3[2];
                    wd  = f3[1:0];
                    imm = (opc == OPC_LOAD) ? IMM_I : IMM_S;
                    s2  = SRC2_IMM;
                end
            end
            OPC_OP_IMM: begin
                lg = (f3 == 3'd1) ? (f7 == 7'h00) :
                     (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                if (lg) begin
                    r1  = 1'b1;
                    rdw = 1'b1;
                    op  = f3;
                    sub = (f3 == 3'd5) ? w[30] : (f3 == 3'd2 || f3 == 3'd3);
                    imm = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_I;
                    s2  = SRC2_IMM;
                end
            end
            OPC_OP: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    lg  = 1'b1;
                    r1  = 1'b1;
                    r2  = 1'b1;
                    rdw = 1'b1;
                    op  = f3;
                    sub = w[30] || f3 == 3'd2 || f3 == 3'd3;
                end
            end
            OPC_SYSTEM: begin
                if (f3[1:0] != 2'b00) begin
                    lg  = 1'b1;
                    r1  = !f3[2];
                    imm = f3[2] ? IMM_ZIMM : IMM_NONE;
                    s1  = f3[2] ? SRC1_ZERO : SRC1_REG;
                    s2  = f3[2] ? SRC2_IMM : SRC2_ZERO;
                    cop = (f3[1:0] == 2'b01) ? CSR_RW : ((f3[1:0] == 2'b10) ? CSR_RS : CSR_RC);
                    cr  = (f3[1:0] == 2'b01) ? (w[11:7] != 5'd0) : 1'b1;
                    cw  = (f3[1:0] == 2'b01) ? 1'b1 : (w[19:15] != 5'd0);
                    rdw = cr;
                end
            end
            default: begin
                lg = 1'b0;
            end
        endcase
        return {lg, r1, r2, imm, op, sub, s1, s2, mr, mw, wd, zx, cr, cw, cop, br, pcs, rdw};
    endfunction

    function automatic logic [CW_W-1:0] actual_word();
        return {legal, rs1_read, rs2_read, imm_fmt, alu_op, alu_sub_sra, alu_src1, alu_src2,
                mem_read, mem_write, mem_width, mem_zero_extend, csr_read, csr_write,
                csr_write_op, branch_op, branch_pc_src, rd_write};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Decode check stopped the run");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction templates
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_instr(output logic [31:0] w, output string name);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int unsigned pick;
        r    = $urandom;
        rd   = r[11:7];
        rs1  = r[19:15];
        rs2  = r[24:20];
        f3   = r[14:12];
        pick = $urandom_range(0, 11);
        case (pick)
            0, 1, 2, 3, 4: begin
                name = "control_flow";
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd4;
                end
                case (pick)
                    0:       w = {r[31:12], rd, OPC_LUI};
                    1:       w = {r[31:12], rd, OPC_AUIPC};
                    2:       w = {r[31:12], rd, OPC_JAL};
                    3:       w = {r[31:20], rs1, 3'b000, rd, OPC_JALR};
                    default: w = {r[31:25], rs2, rs1, f3, r[11:7], OPC_BRANCH};
                endcase
            end
            5: begin
                name = "memory";
                if (f3 == 3'd3 || f3[2:1] == 2'b11) begin
                    f3 = 3'd2;    // Map the unused widths onto LW
                end
                w = {r[31:20], rs1, f3, rd, OPC_LOAD};
            end
            6: begin
                name = "memory";
                f3 = (r[13:12] == 2'b11) ? 3'd0 : {1'b0, r[13:12]};
                w = {r[31:25], rs2, rs1, f3, r[11:7], OPC_STORE};
            end
            7: begin
                name = "alu";
                f7 = (f3 == 3'd1) ? 7'h00 : ((f3 == 3'd5) ? {1'b0, r[30], 5'b0} : r[31:25]);
                w = {f7, rs2, rs1, f3, rd, OPC_OP_IMM};
            end
            8: begin
                name = "alu";
                f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[30], 5'b0} : 7'h00;
                w = {f7, rs2, rs1, f3, rd, OPC_OP};
            end
            9: begin
                name = "csr";
                if (f3[1:0] == 2'b00) begin
                    f3[0] = 1'b1;
                end
                rd  = r[5] ? 5'd0 : rd;    // Zero rd and rs1 often
                rs1 = r[6] ? 5'd0 : rs1;
                w = {r[31:20], rs1, f3, rd, OPC_SYSTEM};
            end
            10: begin
                name = "illegal";
                case (r[3:0])
                    4'd0:    w = 32'h0ff0_000f;    // FENCE
                    4'd1:    w = 32'h0000_100f;    // FENCE.I
                    4'd2:    w = 32'h0000_0073;    // ECALL
                    4'd3:    w = 32'h0010_0073;    // EBREAK
                    4'd4:    w = 32'h3020_0073;    // MRET
                    4'd5:    w = 32'h1050_0073;    // WFI
                    4'd6:    w = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
                    4'd7:    w = {r[31:20], rs1, 3'b100, rd, OPC_SYSTEM};
                    4'd8:    w = {r[31:20], rs1, f3 | 3'b001, rd, OPC_JALR};
                    4'd9:    w = {r[31:25], rs2, rs1, 2'b01, r[12], r[11:7], OPC_BRANCH};
                    4'd10:   w = {r[31:20], rs1, f3[2], 2'b11, rd, OPC_LOAD};
                    4'd11:   w = {r[31:25], rs2, rs1, 1'b1, f3[1:0], r[11:7], OPC_STORE};
                    default: w = {7'b0100000, rs2, rs1, 3'b001, rd, OPC_OP_IMM};
                endcase
            end
            default: begin
                name = "random_word";
                w = r;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus, compare and timeout
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        int unsigned seed_discard;
        logic [31:0] w;
        string       name;
        instr_valid  = 1'b0;
        instr        = '0;
        seed_discard = $urandom(SEED);
        wait (rst_n === 1'b1);
        check_value("reset", 32'd0, 32'({out_valid, actual_word()}));
        for (int i = 0; i < NUM_INSTR; i++) begin
            @(posedge clk);
            #1;
            if ($urandom_range(0, 3) == 0) begin
                instr_valid = 1'b0;
                instr       = $urandom;    // Ignored while instr_valid is low
                @(posedge clk);
                #1;
            end
            build_instr(w, name);
            instr_valid = 1'b1;
            instr       = w;
            sent_q.push_back(w);
            name_q.push_back(name);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        repeat (3) @(negedge clk);
        if (checked_count == NUM_INSTR && sent_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Only %0d of %0d decoded results came out", checked_count, NUM_INSTR);
            $display("Simulation failed");
            $fatal(1, "Missing results");
        end
    end

    initial begin : compare
        logic        exp_valid;
        logic [31:0] w;
        string       name;
        forever begin
            @(posedge clk);
            exp_valid = rst_n & instr_valid;
            @(negedge clk);
            check_value("timing", 32'(exp_valid), 32'(out_valid));
            if (out_valid) begin
                if (sent_q.size() == 0) begin
                    $display("out_valid is high with no instruction outstanding");
                    $display("Simulation failed");
                    $fatal(1, "Unexpected output");
                end else begin
                    w    = sent_q.pop_front();
                    name = name_q.pop_front();
                    check_value(name, 32'(ref_decode(w)), 32'(actual_word()));
                    checked_count++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Run did not finish within %0d cycles, %0d of %0d results checked",
                         TIMEOUT_CYCLES, checked_count, NUM_INSTR);
                $display("Simulation failed");
                $fatal(1, "Timeout");
            end
        end
    end

endmodule

// File: sim/rv32_decode_properties.sv
module rv32_decode_properties (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic out_valid,
    input logic legal,
    input logic rs1_read,
    input logic rs2_read,
    input logic mem_read,
    input logic mem_write,
    input logic csr_read,
    input logic csr_write,
    input logic rd_write
);
    timeunit 1ns;
    timeprecision 1ps;

    a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid is high after a reset cycle");

    a_no_read_and_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // Legal and the enables only change along with out_valid
    a_fields_hold_without_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable({legal, rs1_read, rs2_read, mem_read, mem_write,
                                csr_read, csr_write, rd_write}))
        else $error("Control fields changed while out_valid is low");

    a_valid_one_cycle_later: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (out_valid == $past(instr_valid)))
        else $error("out_valid does not follow instr_valid by one cycle");

endmodule

bind rv32_decode_stage rv32_decode_properties u_properties (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .out_valid   (out_valid),
    .legal       (legal),
    .rs1_read    (rs1_read),
    .rs2_read    (rs2_read),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .csr_read    (csr_read),
    .csr_write   (csr_write),
    .rd_write    (rd_write)
);

// File: sim/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam realtime HALF_PERIOD = 5ns;
    localparam int      RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;    // Released off the edge like the other inputs
    end

endmodule

// File: hw/rv32_decode_stage.sv
module rv32_decode_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             instr_valid,
    input  logic [rv32_decode_pkg::XLEN-1:0] instr,
    output logic                             out_valid,
    output logic                             legal,
    output logic                             rs1_read,
    output logic                             rs2_read,
    output rv32_decode_pkg::imm_fmt_e        imm_fmt,
    output rv32_decode_pkg::alu_op_e         alu_op,
    output logic                             alu_sub_sra,
    output rv32_decode_pkg::alu_src1_e       alu_src1,
    output rv32_decode_pkg::alu_src2_e       alu_src2,
    output logic                             mem_read,
    output logic                             mem_write,
    output rv32_decode_pkg::mem_width_e      mem_width,
    output logic                             mem_zero_extend,
    output logic                             csr_read,
    output logic                             csr_write,
    output rv32_decode_pkg::csr_write_op_e   csr_write_op,
    output rv32_decode_pkg::branch_op_e      branch_op,
    output rv32_decode_pkg::branch_pc_src_e  branch_pc_src,
    output logic                             rd_write
);
    import rv32_decode_pkg::*;

    instr_class_e   instr_class;
    logic [2:0]     funct3;
    logic           funct7_5;
    imm_fmt_e       dec_imm_fmt;
    alu_op_e        dec_alu_op;
    logic           dec_alu_sub_sra;
    alu_src1_e      dec_alu_src1;
    alu_src2_e      dec_alu_src2;
    logic           dec_mem_read;
    logic           dec_mem_write;
    mem_width_e     dec_mem_width;
    logic           dec_mem_zero_extend;
    branch_op_e     dec_branch_op;
    branch_pc_src_e dec_branch_pc_src;
    logic           dec_rs1_read;
    logic           dec_rs2_read;
    logic           dec_rd_write;
    logic           dec_csr_read;
    logic           dec_csr_write;
    csr_write_op_e  dec_csr_write_op;

    assign funct7_5 = instr[FUNCT7_LSB + 5];

    ////////////////////////////////////////////////////////////////////////////
    // Combinational decoders
    ////////////////////////////////////////////////////////////////////////////

    rv32_instr_classifier u_classifier (
        .instr       (instr),
        .instr_class (instr_class),
        .funct3      (funct3)
    );

    rv32_alu_ctrl u_alu_ctrl (
        .instr_class (instr_class),
        .funct3      (funct3),
        .funct7_5    (funct7_5),
        .imm_fmt     (dec_imm_fmt),
        .alu_op      (dec_alu_op),
        .alu_sub_sra (dec_alu_sub_sra),
        .alu_src1    (dec_alu_src1),
        .alu_src2    (dec_alu_src2)
    );

    rv32_mem_branch_ctrl u_mem_branch_ctrl (
        .instr_class     (instr_class),
        .funct3          (funct3),
        .mem_read        (dec_mem_read),
        .mem_write       (dec_mem_write),
        .mem_width       (dec_mem_width),
        .mem_zero_extend (dec_mem_zero_extend),
        .branch_op       (dec_branch_op),
        .branch_pc_src   (dec_branch_pc_src)
    );

    rv32_reg_csr_ctrl u_reg_csr_ctrl (
        .instr_class  (instr_class),
        .instr        (instr),
        .rs1_read     (dec_rs1_read),
        .rs2_read     (dec_rs2_read),
        .rd_write     (dec_rd_write),
        .csr_read     (dec_csr_read),
        .csr_write    (dec_csr_write),
        .csr_write_op (dec_csr_write_op)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Control word register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid       <= 1'b0;
            legal           <= 1'b0;
            rs1_read        <= 1'b0;
            rs2_read        <= 1'b0;
            imm_fmt         <= IMM_NONE;
            alu_op          <= ALU_ADD_SUB;
            alu_sub_sra     <= 1'b0;
            alu_src1        <= SRC1_REG;
            alu_src2        <= SRC2_REG;
            mem_read        <= 1'b0;
            mem_write       <= 1'b0;
            mem_width       <= MEM_BYTE;
            mem_zero_extend <= 1'b0;
            csr_read        <= 1'b0;
            csr_write       <= 1'b0;
            csr_write_op    <= CSR_RW;
            branch_op       <= BR_NEVER;
            branch_pc_src   <= PC_SRC_IMM;
            rd_write        <= 1'b0;
        end else begin
            out_valid <= instr_valid;
            if (instr_valid) begin    // Fields hold between instructions
                legal           <= (instr_class != CLS_ILLEGAL);
                rs1_read        <= dec_rs1_read;
                rs2_read        <= dec_rs2_read;
                imm_fmt         <= dec_imm_fmt;
                alu_op          <= dec_alu_op;
                alu_sub_sra     <= dec_alu_sub_sra;
                alu_src1        <= dec_alu_src1;
                alu_src2        <= dec_alu_src2;
                mem_read        <= dec_mem_read;
                mem_write       <= dec_mem_write;
                mem_width       <= dec_mem_width;
                mem_zero_extend <= dec_mem_zero_extend;
                csr_read        <= dec_csr_read;
                csr_write       <= dec_csr_write;
                csr_write_op    <= dec_csr_write_op;
                branch_op       <= dec_branch_op;
                branch_pc_src   <= dec_branch_pc_src;
                rd_write        <= dec_rd_write;
            end
        end
    end

endmodule

// File: hw/rv32_reg_csr_ctrl.sv
module rv32_reg_csr_ctrl (
    input  rv32_decode_pkg::instr_class_e  instr_class,
    input  logic [rv32_decode_pkg::XLEN-1:0] instr,
    output logic                           rs1_read,
    output logic                           rs2_read,
    output logic                           rd_write,
    output logic                           csr_read,
    output logic                           csr_write,
    output rv32_decode_pkg::csr_write_op_e csr_write_op
);
    import rv32_decode_pkg::*;

    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;    // Holds the uimm for the immediate CSR forms
    logic [2:0]            funct3;
    logic                  csr_swap;

    assign rd       = instr[RD_MSB:RD_LSB];
    assign rs1      = instr[RS1_MSB:RS1_LSB];
    assign funct3   = instr[FUNCT3_MSB:FUNCT3_LSB];
    assign csr_swap = (funct3[1:0] == 2'b01);

    always_comb begin
        rs1_read     = instr_class inside {CLS_JALR, CLS_BRANCH, CLS_LOAD, CLS_STORE,
                                           CLS_OP_IMM, CLS_OP};
        rs2_read     = instr_class inside {CLS_BRANCH, CLS_STORE, CLS_OP};
        rd_write     = instr_class inside {CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR,
                                           CLS_LOAD, CLS_OP_IMM, CLS_OP};
        csr_read     = 1'b0;
        csr_write    = 1'b0;
        csr_write_op = CSR_RW;

        if (instr_class == CLS_CSR) begin
            rs1_read = !funct3[2];
            // A swap with rd zero skips the read, a set or clear with rs1 zero skips the write
            csr_read  = csr_swap ? (|rd) : 1'b1;
            rd_write  = csr_read;
            csr_write = csr_swap ? 1'b1 : (|rs1);
            case (funct3[1:0])
                2'b10:   csr_write_op = CSR_RS;
                2'b11:   csr_write_op = CSR_RC;
                default: csr_write_op = CSR_RW;
            endcase
        end
    end

endmodule

// File: hw/rv32_mem_branch_ctrl.sv
module rv32_mem_branch_ctrl (
    input  rv32_decode_pkg::instr_class_e   instr_class,
    input  logic [2:0]                      funct3,
    output logic                            mem_read,
    output logic                            mem_write,
    output rv32_decode_pkg::mem_width_e     mem_width,
    output logic                            mem_zero_extend,
    output rv32_decode_pkg::branch_op_e     branch_op,
    output rv32_decode_pkg::branch_pc_src_e branch_pc_src
);
    import rv32_decode_pkg::*;

    always_comb begin
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_width       = MEM_BYTE;
        mem_zero_extend = 1'b0;
        branch_op       = BR_NEVER;
        branch_pc_src   = PC_SRC_IMM;

        case (instr_class)
            CLS_LOAD: begin
                mem_read        = 1'b1;
                mem_width       = mem_width_e'(funct3[1:0]);
                mem_zero_extend = funct3[2];    // LBU and LHU
            end
            CLS_STORE: begin
                mem_write = 1'b1;
                mem_width = mem_width_e'(funct3[1:0]);
            end
            CLS_BRANCH: begin
                // BNE, BLT and BLTU take the branch on a nonzero ALU result
                branch_op = (funct3[2] ^ funct3[0]) ? BR_NON_ZERO : BR_ZERO;
            end
            CLS_JAL: begin
                branch_op = BR_ALWAYS;
            end
            CLS_JALR: begin
                branch_op     = BR_ALWAYS;
                branch_pc_src = PC_SRC_REG;
            end
            default: begin
                branch_op = BR_NEVER;
            end
        endcase
    end

endmodule

// File: hw/rv32_alu_ctrl.sv
module rv32_alu_ctrl (
    input  rv32_decode_pkg::instr_class_e instr_class,
    input  logic [2:0]                    funct3,
    input  logic                          funct7_5,
    output rv32_decode_pkg::imm_fmt_e     imm_fmt,
    output rv32_decode_pkg::alu_op_e      alu_op,
    output logic                          alu_sub_sra,
    output rv32_decode_pkg::alu_src1_e    alu_src1,
    output rv32_decode_pkg::alu_src2_e    alu_src2
);
    import rv32_decode_pkg::*;

    logic is_slt;

    assign is_slt = (funct3[2:1] == 2'b01);    // SLT and SLTU compare by subtracting

    always_comb begin
        imm_fmt     = IMM_NONE;
        alu_op      = ALU_ADD_SUB;
        alu_sub_sra = 1'b0;
        alu_src1    = SRC1_REG;
        alu_src2    = SRC2_REG;

        case (instr_class)
            CLS_LUI: begin
                imm_fmt  = IMM_U;
                alu_src1 = SRC1_ZERO;
                alu_src2 = SRC2_IMM;
            end
            CLS_AUIPC: begin
                imm_fmt  = IMM_U;
                alu_src1 = SRC1_PC;
                alu_src2 = SRC2_IMM;
            end
            CLS_JAL, CLS_JALR: begin
                imm_fmt  = (instr_class == CLS_JAL) ? IMM_J : IMM_I;
                alu_src1 = SRC1_PC;    // The ALU forms the link address
                alu_src2 = SRC2_FOUR;
            end
            CLS_BRANCH: begin
                imm_fmt     = IMM_B;
                alu_sub_sra = 1'b1;
                case (funct3[2:1])
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: alu_op = ALU_ADD_SUB;
                endcase
            end
            CLS_LOAD, CLS_STORE: begin
                imm_fmt  = (instr_class == CLS_LOAD) ? IMM_I : IMM_S;
                alu_src2 = SRC2_IMM;
            end
            CLS_OP_IMM: begin
                imm_fmt     = (funct3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;
                alu_op      = alu_op_e'(funct3);
                alu_sub_sra = (funct3 == 3'b101) ? funct7_5 : is_slt;
                alu_src2    = SRC2_IMM;
            end
            CLS_OP: begin
                alu_op      = alu_op_e'(funct3);
                alu_sub_sra = funct7_5 | is_slt;
            end
            CLS_CSR: begin
                // The write value passes through the adder unchanged
                imm_fmt  = funct3[2] ? IMM_ZIMM : IMM_NONE;
                alu_src1 = funct3[2] ? SRC1_ZERO : SRC1_REG;
                alu_src2 = funct3[2] ? SRC2_IMM : SRC2_ZERO;
            end
            default: begin
                imm_fmt = IMM_NONE;
            end
        endcase
    end

endmodule

// File: hw/rv32_instr_classifier.sv
module rv32_instr_classifier (
    input  logic [rv32_decode_pkg::XLEN-1:0] instr,
    output rv32_decode_pkg::instr_class_e    instr_class,
    output logic [2:0]                       funct3
);
    import rv32_decode_pkg::*;

    opcode_e    opcode;
    logic [6:0] funct7;
    logic       f7_zero;
    logic       f7_alt;

    assign opcode  = opcode_e'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign funct3  = instr[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7  = instr[FUNCT7_MSB:FUNCT7_LSB];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);    // SUB, SRA and SRAI

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and function field match
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        instr_class = CLS_ILLEGAL;

        case (opcode)
            OPC_LUI: begin
                instr_class = CLS_LUI;
            end
            OPC_AUIPC: begin
                instr_class = CLS_AUIPC;
            end
            OPC_JAL: begin
                instr_class = CLS_JAL;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    instr_class = CLS_JALR;
                end
            end
            OPC_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin    // funct3 2 and 3 are unused
                    instr_class = CLS_BRANCH;
                end
            end
            OPC_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    instr_class = CLS_LOAD;
                end
            end
            OPC_STORE: begin
                if (!funct3[2] && funct3[1:0] != 2'b11) begin
                    instr_class = CLS_STORE;
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b001: begin
                        if (f7_zero) begin
                            instr_class = CLS_OP_IMM;
                        end
                    end
                    3'b101: begin
                        if (f7_zero || f7_alt) begin
                            instr_class = CLS_OP_IMM;
                        end
                    end
                    default: begin
                        instr_class = CLS_OP_IMM;    // Upper bits are immediate
                    end
                endcase
            end
            OPC_OP: begin
                if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    instr_class = CLS_OP;
                end
            end
            OPC_SYSTEM: begin
                // funct3 0 holds ECALL, EBREAK, MRET and WFI, and 4 is reserved
                if (funct3[1:0] != 2'b00) begin
                    instr_class = CLS_CSR;
                end
            end
            default: begin
                instr_class = CLS_ILLEGAL;
            end
        endcase
    end

endmodule

// File: hw/rv32_decode_pkg.sv
package rv32_decode_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word layout
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011    // Only the CSR forms are kept
    } opcode_e;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_CSR,
        CLS_ILLEGAL
    } instr_class_e;

    ////////////////////////////////////////////////////////////////////////////
    // Control word fields
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,
        IMM_ZIMM
    } imm_fmt_e;

    // Same order as funct3 of the OP and OP-IMM groups
    typedef enum logic [2:0] {
        ALU_ADD_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG,
        SRC1_PC,
        SRC1_ZERO
    } alu_src1_e;

    typedef enum logic [1:0] {
        SRC2_REG,
        SRC2_IMM,
        SRC2_FOUR,
        SRC2_ZERO
    } alu_src2_e;

    typedef enum logic [1:0] {
        MEM_BYTE,    // Matches funct3[1:0] of loads and stores
        MEM_HALF,
        MEM_WORD
    } mem_width_e;

    typedef enum logic [1:0] {
        BR_NEVER,
        BR_ZERO,
        BR_NON_ZERO,
        BR_ALWAYS
    } branch_op_e;

    typedef enum logic {
        PC_SRC_IMM,
        PC_SRC_REG
    } branch_pc_src_e;

    typedef enum logic [1:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC
    } csr_write_op_e;

endpackage
